// ==== test/alu_issue_stim.txt ====
# name inst pc rs1 rs2 rob_idx pred_taken pred_target stall_cycles(decimal)
# then expected wb_data br_taken br_target br_mispredict, all other columns hex
add 007302b3 00000000 7fffffff 00000001 00 0 00000000 0 80000000 0 00000000 0
sub 407302b3 00000004 00000005 00000007 01 0 00000000 12 fffffffe 0 00000000 0
and 007372b3 00000008 f0f0f0f0 ff00ff00 02 0 00000000 0 f000f000 0 00000000 0
or 007362b3 0000000c 12340000 00005678 03 0 00000000 0 12345678 0 00000000 0
xor 007342b3 00000010 aaaa5555 ffff0000 04 0 00000000 0 55555555 0 00000000 0
addi ffb30293 00000014 00000003 00000000 05 0 00000000 0 fffffffe 0 00000000 0
xori 0f034293 00000018 0000ffff 00000000 06 0 00000000 0 0000ff0f 0 00000000 0
slt 007322b3 0000001c fffffffe 00000003 07 0 00000000 0 00000001 0 00000000 0
sltu 007332b3 00000020 fffffffe 00000003 08 0 00000000 0 00000000 0 00000000 0
sll 007312b3 00000024 00000001 0000003f 09 0 00000000 0 80000000 0 00000000 0
srl 007352b3 00000028 80000000 00000004 0a 0 00000000 0 08000000 0 00000000 0
sra 407352b3 0000002c 80000000 00000004 0b 0 00000000 0 f8000000 0 00000000 0
srai 40435293 00000030 8000f000 00000000 0c 0 00000000 0 f8000f00 0 00000000 0
lui 123452b7 00000034 00000000 00000000 0d 0 00000000 0 12345000 0 00000000 0
auipc 00010297 00002004 00000000 00000000 0e 0 00000000 0 00012004 0 00000000 0
beq 00730863 00000100 0000abcd 0000abcd 0f 1 00000110 8 00000104 1 00000110 0
bne fe731ce3 00000200 00000001 00000002 10 0 00000000 0 00000204 1 000001f8 1
blt 02734063 00000300 ffffffff 00000001 11 1 00000330 0 00000304 1 00000320 1
bltu 02736063 00000340 ffffffff 00000001 12 0 00000000 0 00000344 0 00000344 0
jal 100000ef 00000500 00000000 00000000 13 0 00000000 0 00000504 1 00000600 0
jalr 003300e7 00000600 00001000 00000000 14 1 00001002 0 00000604 1 00001002 0
jalr_miss ffc300e7 00000700 00002001 00000000 15 0 00001ffc 0 00000704 1 00001ffc 1

// ==== alu_issue_top.f ====
design/alu_pkg.sv
design/uop_decode.sv
design/alu_issue_queue.sv
design/int_alu.sv
design/branch_unit.sv
design/alu_exec.sv
design/alu_issue_top.sv
test/alu_issue_chk.sv
test/alu_issue_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -Wno-fatal -j 0 \
        --top-module alu_issue_tb -f alu_issue_top.f -o alu_issue_sim \
    && ./obj_dir/alu_issue_sim | tee /dev/stderr | grep -q "Simulation finished: PASS" \
    && echo "run_sim: simulation passed" \
    || { echo "run_sim: simulation failed"; exit 1; }

// ==== test/alu_issue_tb.sv ====
`timescale 1ns/100ps

module alu_issue_tb;
    import alu_pkg::*;

    localparam int max_lines = 64;
    localparam int reset_cycles = 8;
    localparam int cycles_per_line = 40;

    logic clk;
    logic reset;
    logic inst_valid;
    logic [31:0] inst;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic [rob_idx_width-1:0] rob_idx;
    logic pred_taken;
    logic [xlen-1:0] pred_target;
    logic wb_stall;
    logic issue_full;
    logic wb_valid;
    logic wb_we;
    logic [rob_idx_width-1:0] wb_rob_idx;
    logic [reg_addr_width-1:0] wb_rd;
    logic [xlen-1:0] wb_data;
    logic br_valid;
    logic br_taken;
    logic [xlen-1:0] br_target;
    logic br_mispredict;

    // one entry per data line of the stimulus file
    string line_name [max_lines];
    logic [31:0] line_inst [max_lines];
    logic [31:0] line_pc [max_lines];
    logic [31:0] line_rs1 [max_lines];
    logic [31:0] line_rs2 [max_lines];
    logic [31:0] line_rob [max_lines];
    logic [31:0] line_pred_taken [max_lines];
    logic [31:0] line_pred_target [max_lines];
    int line_stall [max_lines];
    logic [31:0] line_data [max_lines];
    logic [31:0] line_taken [max_lines];
    logic [31:0] line_target [max_lines];
    logic [31:0] line_mispredict [max_lines];

    int num_lines;
    int errors;
    int checked;
    int expect_q [$];
    logic loaded;
    logic full_seen;

    alu_issue_top alu_issue_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // branches and jumps resolve through the branch unit, conditional branches write nothing
    function automatic logic resolves_branch(input logic [31:0] word);
        return word[6:0] == 7'b1100011 || word[6:0] == 7'b1101111 || word[6:0] == 7'b1100111;
    endfunction

    function automatic logic writes_register(input logic [31:0] word);
        return word[6:0] != 7'b1100011;
    endfunction

    task automatic compare_field(input string test, input string field,
                                 input logic [31:0] expected, input logic [31:0] actual);
        assert (actual == expected) else begin
            $display("FAIL %s %s expected %h actual %h", test, field, expected, actual);
            errors++;
        end
    endtask

    task automatic load_stimulus();
        int fd;
        int code;
        string name;
        string rest;
        fd = $fopen("test/alu_issue_stim.txt", "r");
        if (fd == 0) begin
            $display("the stimulus file could not be opened");
            errors++;
            return;
        end
        while (num_lines < max_lines) begin
            code = $fscanf(fd, "%s", name);
            if (code != 1) break;
            if (name.substr(0, 0) == "#") begin
                code = $fgets(rest, fd);
            end else begin
                line_name[num_lines] = name;
                code = $fscanf(fd, " %h %h %h %h %h %h %h %d %h %h %h %h",
                               line_inst[num_lines], line_pc[num_lines], line_rs1[num_lines],
                               line_rs2[num_lines], line_rob[num_lines],
                               line_pred_taken[num_lines], line_pred_target[num_lines],
                               line_stall[num_lines], line_data[num_lines],
                               line_taken[num_lines], line_target[num_lines],
                               line_mispredict[num_lines]);
                if (code != 12) begin
                    $display("stimulus line for %s is incomplete", name);
                    errors++;
                    break;
                end
                num_lines++;
            end
        end
        $fclose(fd);
    endtask

    // random gaps between strobes, and a stall window opened by lines that ask for one
    task automatic drive_stimulus();
        int idx;
        int gap;
        int stall_left;
        idx = 0;
        gap = 0;
        stall_left = 0;
        while (idx < num_lines || stall_left > 0) begin
            @(posedge clk);
            inst_valid <= 1'b0;
            wb_stall <= (stall_left > 0);
            if (stall_left > 0) stall_left--;
            if (gap > 0) begin
                gap--;
            end else if (idx < num_lines && !issue_full) begin
                inst_valid <= 1'b1;
                inst <= line_inst[idx];
                pc <= line_pc[idx];
                rs1_data <= line_rs1[idx];
                rs2_data <= line_rs2[idx];
                rob_idx <= line_rob[idx][rob_idx_width-1:0];
                pred_taken <= line_pred_taken[idx][0];
                pred_target <= line_pred_target[idx];
                expect_q.push_back(idx);
                if (line_stall[idx] > 0) stall_left = line_stall[idx];
                gap = $urandom_range(2, 0);
                idx++;
            end
        end
        @(posedge clk);
        inst_valid <= 1'b0;
        wb_stall <= 1'b0;
    endtask

    task automatic check_writeback();
        int idx;
        if (expect_q.size() == 0) begin
            $display("a writeback for rob_idx %0d arrived with nothing outstanding", wb_rob_idx);
            errors++;
            return;
        end
        idx = expect_q.pop_front();
        checked++;
        compare_field(line_name[idx], "rob_idx", line_rob[idx], 32'(wb_rob_idx));
        compare_field(line_name[idx], "wb_data", line_data[idx], wb_data);
        compare_field(line_name[idx], "wb_we", 32'(writes_register(line_inst[idx])), 32'(wb_we));
        if (writes_register(line_inst[idx])) begin
            compare_field(line_name[idx], "wb_rd", 32'(line_inst[idx][11:7]), 32'(wb_rd));
        end
        compare_field(line_name[idx], "br_valid", 32'(resolves_branch(line_inst[idx])),
                      32'(br_valid));
        if (resolves_branch(line_inst[idx])) begin
            compare_field(line_name[idx], "br_taken", line_taken[idx], 32'(br_taken));
            compare_field(line_name[idx], "br_target", line_target[idx], br_target);
            compare_field(line_name[idx], "br_mispredict", line_mispredict[idx],
                          32'(br_mispredict));
        end
    endtask

    initial begin
        forever begin
            @(posedge clk);
            if (!reset && wb_stall && issue_full) full_seen = 1'b1;
            if (!reset && wb_valid) check_writeback();
        end
    end

    initial begin
        wait (loaded);
        repeat (reset_cycles + cycles_per_line * num_lines) @(posedge clk);
        $display("watchdog expired with %0d of %0d results seen", checked, num_lines);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        void'($urandom(32'h80b98641));
        errors = 0;
        checked = 0;
        num_lines = 0;
        loaded = 1'b0;
        full_seen = 1'b0;
        reset = 1'b1;
        inst_valid = 1'b0;
        inst = '0;
        pc = '0;
        rs1_data = '0;
        rs2_data = '0;
        rob_idx = '0;
        pred_taken = 1'b0;
        pred_target = '0;
        wb_stall = 1'b0;
        load_stimulus();
        loaded = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
        drive_stimulus();
        wait (checked == num_lines);
        repeat (8) @(posedge clk);
        // a held stall must back the queue up until decode is told to wait
        assert (full_seen) else begin
            $display("issue_full never rose while wb_stall held the queue back");
            errors++;
        end
        $display("checked %0d of %0d results, %0d errors", checked, num_lines, errors);
        if (errors == 0 && num_lines > 0 && checked == num_lines && expect_q.size() == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== test/alu_issue_chk.sv ====
`timescale 1ns/100ps

module alu_issue_chk (
    input logic clk,
    input logic reset,
    input logic push,
    input logic pop,
    input logic empty,
    input logic wb_stall,
    input logic wb_valid,
    input logic wb_we,
    input logic br_valid,
    input logic br_taken
);
    import alu_pkg::*;

    // occupancy seen from the push and pop strobes at the top level
    logic [2:0] occupancy;

    always_ff @(posedge clk) begin
        if (reset) begin
            occupancy <= '0;
        end else if (push && !pop) begin
            occupancy <= occupancy + 3'd1;
        end else if (pop && !push) begin
            occupancy <= occupancy - 3'd1;
        end
    end

    push_not_full: assert property (@(posedge clk) disable iff (reset)
        push |-> (occupancy < 3'(queue_depth)))
        else $error("push arrived with the queue already holding %0d entries", occupancy);

    pop_not_empty: assert property (@(posedge clk) disable iff (reset)
        pop |-> (occupancy != 3'd0))
        else $error("pop issued while the queue held no entries");

    stall_blocks_wb: assert property (@(posedge clk) disable iff (reset)
        (wb_stall && !empty) |=> !wb_valid)
        else $error("writeback appeared right after a stalled cycle");

    // a branch op that writes a register is a jump, and jumps are always taken
    br_needs_wb: assert property (@(posedge clk) disable iff (reset)
        br_valid |-> (wb_valid && (!wb_we || br_taken)))
        else $error("branch resolution without a writeback, or a linking jump not taken");

endmodule

bind alu_issue_top alu_issue_chk alu_issue_chk_inst (
    .clk(clk),
    .reset(reset),
    .push(push),
    .pop(pop),
    .empty(empty),
    .wb_stall(wb_stall),
    .wb_valid(wb_valid),
    .wb_we(wb_we),
    .br_valid(br_valid),
    .br_taken(br_taken)
);

// ==== design/alu_issue_top.sv ====
`timescale 1ns/100ps

module alu_issue_top (
    input logic clk,
    input logic reset,
    input logic inst_valid,
    input logic [31:0] inst,
    input logic [alu_pkg::xlen-1:0] pc,
    input logic [alu_pkg::xlen-1:0] rs1_data,
    input logic [alu_pkg::xlen-1:0] rs2_data,
    input logic [alu_pkg::rob_idx_width-1:0] rob_idx,
    input logic pred_taken,
    input logic [alu_pkg::xlen-1:0] pred_target,
    input logic wb_stall,
    output logic issue_full,
    output logic wb_valid,
    output logic wb_we,
    output logic [alu_pkg::rob_idx_width-1:0] wb_rob_idx,
    output logic [alu_pkg::reg_addr_width-1:0] wb_rd,
    output logic [alu_pkg::xlen-1:0] wb_data,
    output logic br_valid,
    output logic br_taken,
    output logic [alu_pkg::xlen-1:0] br_target,
    output logic br_mispredict
);
    import alu_pkg::*;

    logic push;
    logic pop;
    logic empty;
    uop_t push_uop;
    uop_t head_uop;

    uop_decode uop_decode_inst (
        .clk(clk),
        .reset(reset),
        .inst_valid(inst_valid),
        .inst(inst),
        .pc(pc),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .rob_idx(rob_idx),
        .pred_taken(pred_taken),
        .pred_target(pred_target),
        .push(push),
        .push_uop(push_uop)
    );

    alu_issue_queue alu_issue_queue_inst (
        .clk(clk),
        .reset(reset),
        .push(push),
        .push_uop(push_uop),
        .pop(pop),
        .head_uop(head_uop),
        .empty(empty),
        .issue_full(issue_full)
    );

    alu_exec alu_exec_inst (
        .clk(clk),
        .reset(reset),
        .head_uop(head_uop),
        .empty(empty),
        .wb_stall(wb_stall),
        .pop(pop),
        .wb_valid(wb_valid),
        .wb_we(wb_we),
        .wb_rob_idx(wb_rob_idx),
        .wb_rd(wb_rd),
        .wb_data(wb_data),
        .br_valid(br_valid),
        .br_taken(br_taken),
        .br_target(br_target),
        .br_mispredict(br_mispredict)
    );

endmodule

// ==== design/alu_exec.sv ====
`timescale 1ns/100ps

module alu_exec (
    input logic clk,
    input logic reset,
    input alu_pkg::uop_t head_uop,
    input logic empty,
    input logic wb_stall,
    output logic pop,
    output logic wb_valid,
    output logic wb_we,
    output logic [alu_pkg::rob_idx_width-1:0] wb_rob_idx,
    output logic [alu_pkg::reg_addr_width-1:0] wb_rd,
    output logic [alu_pkg::xlen-1:0] wb_data,
    output logic br_valid,
    output logic br_taken,
    output logic [alu_pkg::xlen-1:0] br_target,
    output logic br_mispredict
);
    import alu_pkg::*;

    logic [xlen-1:0] alu_result;
    logic taken;
    logic mispredict;
    logic [xlen-1:0] target;
    logic [xlen-1:0] link;

    int_alu int_alu_inst (
        .uop(head_uop),
        .result(alu_result)
    );

    branch_unit branch_unit_inst (
        .uop(head_uop),
        .taken(taken),
        .mispredict(mispredict),
        .target(target),
        .link(link)
    );

    assign pop = ~empty & ~wb_stall;

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_valid <= 1'b0;
            br_valid <= 1'b0;
        end else begin
            wb_valid <= pop;
            br_valid <= pop & (head_uop.branch_op != br_none);
        end
    end

    // jumps write the link address, everything else the ALU result
    always_ff @(posedge clk) begin
        if (pop) begin
            wb_we <= head_uop.we;
            wb_rob_idx <= head_uop.rob_idx;
            wb_rd <= head_uop.rd;
            wb_data <= head_uop.is_int ? alu_result : link;
            br_taken <= taken;
            br_target <= target;
            br_mispredict <= mispredict;
        end
    end

endmodule

// ==== design/branch_unit.sv ====
`timescale 1ns/100ps

module branch_unit (
    input alu_pkg::uop_t uop,
    output logic taken,
    output logic mispredict,
    output logic [alu_pkg::xlen-1:0] target,
    output logic [alu_pkg::xlen-1:0] link
);
    import alu_pkg::*;

    logic equal;
    logic ucmp;
    logic scmp;
    logic cmp_result;
    logic dir;
    logic is_cond;
    logic [xlen-1:0] br_off;
    logic [xlen-1:0] jal_off;
    logic [xlen-1:0] pc_target;
    logic [xlen-1:0] jalr_sum;
    logic [xlen-1:0] jalr_target;

    assign equal = uop.rs1_data == uop.rs2_data;
    assign ucmp = uop.rs1_data < uop.rs2_data;

    always_comb begin
        case ({uop.rs1_data[xlen_msb], uop.rs2_data[xlen_msb]})
            2'b01: scmp = 1'b0;
            2'b10: scmp = 1'b1;
            default: scmp = ucmp;
        endcase
    end

    assign cmp_result = uop.unsigned_cmp ? ucmp : scmp;

    always_comb begin
        case (uop.branch_op)
            br_beq: dir = equal;
            br_bne: dir = ~equal;
            br_blt: dir = cmp_result;
            br_bge: dir = ~cmp_result;
            default: dir = 1'b0;
        endcase
    end

    assign is_cond = (uop.branch_op == br_beq) | (uop.branch_op == br_bne) |
                     (uop.branch_op == br_blt) | (uop.branch_op == br_bge);

    assign br_off = {{(xlen - 13){uop.imm.short_view.offset[12]}}, uop.imm.short_view.offset};
    assign jal_off = {{(xlen - 21){uop.imm.upper[19]}}, uop.imm.upper, 1'b0};

    // one pc-relative adder for both jal and conditional branches
    assign pc_target = uop.pc + ((uop.branch_op == br_jal) ? jal_off : br_off);
    assign jalr_sum = uop.rs1_data + br_off;
    assign jalr_target = {jalr_sum[xlen-1:1], 1'b0};
    assign link = uop.pc + 32'd4;

    assign taken = dir | (uop.branch_op == br_jal) | (uop.branch_op == br_jalr);

    always_comb begin
        if (uop.branch_op == br_jalr) begin
            target = jalr_target;
        end else if (dir || uop.branch_op == br_jal) begin
            target = pc_target;
        end else begin
            target = link;
        end
    end

    always_comb begin
        if (uop.branch_op == br_jalr) begin
            mispredict = ~uop.pred_taken | (uop.pred_target != jalr_target);
        end else if (is_cond) begin
            mispredict = (uop.pred_taken ^ dir) |
                         (uop.pred_taken & dir & (uop.pred_target != pc_target));
        end else begin
            mispredict = 1'b0;
        end
    end

endmodule

// ==== design/int_alu.sv ====
`timescale 1ns/100ps

module int_alu (
    input alu_pkg::uop_t uop,
    output logic [alu_pkg::xlen-1:0] result
);
    import alu_pkg::*;

    logic [xlen-1:0] s_imm;
    logic [xlen-1:0] lui_imm;
    logic [xlen-1:0] data1;
    logic [xlen-1:0] data2;
    logic [xlen-1:0] add_src2;
    logic add_cin;
    logic add_cout;
    logic [xlen-1:0] add_result;
    logic scmp;
    logic ucmp;
    logic padding;
    logic [shamt_width-1:0] shamt;
    logic [xlen:0] sr_ext;
    logic [xlen-1:0] sl_data;
    logic [xlen-1:0] auipc_addr;

    assign s_imm = {{(xlen - 13){uop.imm.short_view.offset[12]}}, uop.imm.short_view.offset};
    assign lui_imm = {uop.imm.upper, 12'b0};

    assign data1 = uop.rs1_data;
    assign data2 = uop.imm_valid ? s_imm : uop.rs2_data;

    // sub and slt reuse the adder as data1 + ~data2 + 1
    always_comb begin
        case (uop.int_op)
            int_sub, int_slt: begin
                add_src2 = ~data2;
                add_cin = 1'b1;
            end
            default: begin
                add_src2 = data2;
                add_cin = 1'b0;
            end
        endcase
    end

    assign {add_cout, add_result} = {1'b0, data1} + {1'b0, add_src2} + {{xlen{1'b0}}, add_cin};

    // negative minus non-negative is always less, otherwise the difference sign decides
    assign scmp = (data1[xlen_msb] & ~data2[xlen_msb]) |
                  ((data1[xlen_msb] ~^ data2[xlen_msb]) & add_result[xlen_msb]);
    assign ucmp = ~add_cout;

    assign shamt = data2[shamt_width-1:0];
    assign padding = data1[xlen_msb] & ~uop.unsigned_cmp;
    assign sr_ext = $signed({padding, data1}) >>> shamt;
    assign sl_data = data1 << shamt;

    assign auipc_addr = uop.pc + lui_imm;

    always_comb begin
        case (uop.int_op)
            int_add, int_sub: result = add_result;
            int_slt: result = {{xlen_msb{1'b0}}, uop.unsigned_cmp ? ucmp : scmp};
            int_and: result = data1 & data2;
            int_or: result = data1 | data2;
            int_xor: result = data1 ^ data2;
            int_sl: result = sl_data;
            int_sr: result = sr_ext[xlen-1:0];
            int_lui: result = lui_imm;
            int_auipc: result = auipc_addr;
            default: result = '0;
        endcase
    end

endmodule

// ==== design/alu_issue_queue.sv ====
`timescale 1ns/100ps

module alu_issue_queue (
    input logic clk,
    input logic reset,
    input logic push,
    input alu_pkg::uop_t push_uop,
    input logic pop,
    output alu_pkg::uop_t head_uop,
    output logic empty,
    output logic issue_full
);
    import alu_pkg::*;

    uop_t entries [queue_depth];
    logic [queue_ptr_width-1:0] rd_ptr;
    logic [queue_ptr_width-1:0] wr_ptr;
    logic [queue_count_width-1:0] count;
    logic [queue_count_width-1:0] pending;

    assign head_uop = entries[rd_ptr];
    assign empty = (count == '0);

    // the push already in flight counts, so decode always finds a slot
    assign pending = count + queue_count_width'(push);
    assign issue_full = pending >= queue_count_width'(queue_depth - 1);

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= push_uop;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== design/uop_decode.sv ====
`timescale 1ns/100ps

module uop_decode (
    input logic clk,
    input logic reset,
    input logic inst_valid,
    input logic [31:0] inst,
    input logic [alu_pkg::xlen-1:0] pc,
    input logic [alu_pkg::xlen-1:0] rs1_data,
    input logic [alu_pkg::xlen-1:0] rs2_data,
    input logic [alu_pkg::rob_idx_width-1:0] rob_idx,
    input logic pred_taken,
    input logic [alu_pkg::xlen-1:0] pred_target,
    output logic push,
    output alu_pkg::uop_t push_uop
);
    import alu_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic funct7_ok;
    uop_t uop_d;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    // only 0000000 is legal, plus 0100000 for sub and sra
    assign funct7_ok = ~inst[31] & (inst[29:25] == 5'b0) &
                       (~inst[30] | (funct3 == 3'b000) | (funct3 == 3'b101));

    always_comb begin
        uop_d = '0;
        uop_d.is_int = 1'b1;
        uop_d.int_op = int_none;
        uop_d.branch_op = br_none;
        uop_d.rs1_data = rs1_data;
        uop_d.rs2_data = rs2_data;
        uop_d.pc = pc;
        uop_d.rob_idx = rob_idx;
        uop_d.rd = inst[11:7];
        uop_d.pred_taken = pred_taken;
        uop_d.pred_target = pred_target;
        case (opcode)
            opc_lui, opc_auipc: begin
                uop_d.int_op = (opcode == opc_lui) ? int_lui : int_auipc;
                uop_d.imm.upper = inst[31:12];
                uop_d.we = 1'b1;
            end
            opc_jal: begin
                uop_d.is_int = 1'b0;
                uop_d.branch_op = br_jal;
                uop_d.imm.upper = {inst[31], inst[19:12], inst[20], inst[30:21]};
                uop_d.we = 1'b1;
            end
            opc_jalr: begin
                uop_d.is_int = 1'b0;
                uop_d.branch_op = br_jalr;
                uop_d.imm.short_view.offset = {inst[31], inst[31:20]};
                uop_d.we = 1'b1;
            end
            opc_branch: begin
                // funct3 010 and 011 are not branches and stay as none
                if (funct3[2:1] != 2'b01) begin
                    uop_d.is_int = 1'b0;
                    uop_d.unsigned_cmp = funct3[1];
                    uop_d.imm.short_view.offset =
                        {inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
                    case (funct3)
                        3'b000: uop_d.branch_op = br_beq;
                        3'b001: uop_d.branch_op = br_bne;
                        3'b100, 3'b110: uop_d.branch_op = br_blt;
                        default: uop_d.branch_op = br_bge;
                    endcase
                end
            end
            opc_op_imm, opc_op: begin
                uop_d.imm_valid = (opcode == opc_op_imm);
                uop_d.imm.short_view.offset = {inst[31], inst[31:20]};
                uop_d.we = 1'b1;
                case (funct3)
                    3'b000: uop_d.int_op = (opcode == opc_op && inst[30]) ? int_sub : int_add;
                    3'b001: uop_d.int_op = int_sl;
                    3'b010: uop_d.int_op = int_slt;
                    3'b011: uop_d.int_op = int_slt;
                    3'b100: uop_d.int_op = int_xor;
                    3'b101: uop_d.int_op = int_sr;
                    3'b110: uop_d.int_op = int_or;
                    default: uop_d.int_op = int_and;
                endcase
                // sltu and srl share the unsigned flag, sra keeps the sign fill
                uop_d.unsigned_cmp = (funct3 == 3'b011) | ((funct3 == 3'b101) & ~inst[30]);
                if (opcode == opc_op && !funct7_ok) begin
                    uop_d.int_op = int_none;
                    uop_d.we = 1'b0;
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            push <= 1'b0;
        end else begin
            push <= inst_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (inst_valid) begin
            push_uop <= uop_d;
        end
    end

endmodule

// ==== design/alu_pkg.sv ====
package alu_pkg;

    localparam int xlen = 32;
    localparam int xlen_msb = xlen - 1;
    localparam int shamt_width = 5;
    localparam int rob_idx_width = 5;
    localparam int reg_addr_width = 5;
    localparam int dec_imm_width = 20;
    localparam int queue_depth = 4;
    localparam int queue_ptr_width = 2;
    localparam int queue_count_width = 3;

    // RV32I major opcodes handled by the slice
    localparam logic [6:0] opc_lui = 7'b0110111;
    localparam logic [6:0] opc_auipc = 7'b0010111;
    localparam logic [6:0] opc_jal = 7'b1101111;
    localparam logic [6:0] opc_jalr = 7'b1100111;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_op = 7'b0110011;

    typedef enum logic [3:0] {
        int_add = 4'd0,
        int_sub = 4'd1,
        int_slt = 4'd2,
        int_and = 4'd3,
        int_or = 4'd4,
        int_xor = 4'd5,
        int_sl = 4'd6,
        int_sr = 4'd7,
        int_lui = 4'd8,
        int_auipc = 4'd9,
        int_none = 4'd15
    } int_op_e;

    typedef enum logic [2:0] {
        br_beq = 3'd0,
        br_bne = 3'd1,
        br_blt = 3'd2,
        br_bge = 3'd3,
        br_jal = 3'd4,
        br_jalr = 3'd5,
        br_none = 3'd7
    } branch_op_e;

    // short view holds a signed byte offset, bit 0 is zero for branches
    typedef struct packed {
        logic [6:0] pad;
        logic [12:0] offset;
    } dec_short_t;

    // upper view feeds lui/auipc, and holds imm[20:1] for jal
    typedef union packed {
        logic [dec_imm_width-1:0] upper;
        dec_short_t short_view;
    } dec_imm_u;

    typedef struct packed {
        logic is_int;
        int_op_e int_op;
        branch_op_e branch_op;
        logic imm_valid;
        logic unsigned_cmp;
        dec_imm_u imm;
        logic [xlen-1:0] rs1_data;
        logic [xlen-1:0] rs2_data;
        logic [xlen-1:0] pc;
        logic [rob_idx_width-1:0] rob_idx;
        logic [reg_addr_width-1:0] rd;
        logic we;
        logic pred_taken;
        logic [xlen-1:0] pred_target;
    } uop_t;

endpackage
